// ==== Makefile ====
# Verilator build and run of the bus block testbench

VERILATOR ?= verilator
TOP       ?= tb_bus_int
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^Simulation passed$$" $(LOG) || \
		(echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/bus_int_top.sv ====
// Control and status register block top level that connects decoder, registers, SFP+ monitors and readback
module bus_int_top (
   input  logic                             clk,
   input  logic                             i_reset,

   // Settings bus
   input  logic                             i_set_stb,
   input  logic [bus_pkg::SR_AWIDTH-1:0]    i_set_addr,
   input  logic [bus_pkg::DATA_W-1:0]       i_set_data,

   // Readback bus
   input  logic [bus_pkg::RB_AWIDTH-1:0]    i_rb_addr,
   input  logic                             i_rb_rd_stb,
   output logic [bus_pkg::DATA_W-1:0]       o_rb_data,

   // Status inputs
   input  logic [bus_pkg::CLK_STATUS_W-1:0] i_clock_status,
   input  bus_pkg::sfp_pins_t               i_sfp_pins       [bus_pkg::NUM_SFP],
   input  logic [bus_pkg::PHY_STATUS_W-1:0] i_sfp_phy_status [bus_pkg::NUM_SFP],

   // Control outputs
   output logic [bus_pkg::LEDS_W-1:0]       o_leds,
   output logic [bus_pkg::SW_RST_W-1:0]     o_sw_rst,
   output logic [bus_pkg::CLK_CTRL_W-1:0]   o_clock_control,
   output logic [bus_pkg::DATA_W-1:0]       o_ref_freq,
   output logic                             o_ref_freq_changed,
   output logic [bus_pkg::SFPP_CTRL_W-1:0]  o_sfp_rs_drive   [bus_pkg::NUM_SFP]
);

   logic [bus_pkg::NUM_WR_EN-1:0]   wr_en;
   bus_pkg::rb_sel_t                rb_sel;
   logic                            sfp_clear  [bus_pkg::NUM_SFP];
   logic [bus_pkg::DEVICE_ID_W-1:0] device_id;
   bus_pkg::sfp_status_t            sfp_status [bus_pkg::NUM_SFP];

   setting_decoder decoder0 (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_set_stb   (i_set_stb),
      .i_set_addr  (i_set_addr),
      .i_rb_addr   (i_rb_addr),
      .i_rb_rd_stb (i_rb_rd_stb),
      .o_wr_en     (wr_en),
      .o_rb_sel    (rb_sel),
      .o_sfp_clear (sfp_clear)
   );

   control_regs regs0 (
      .clk                (clk),
      .i_reset            (i_reset),
      .i_wr_en            (wr_en),
      .i_set_data         (i_set_data),
      .o_leds             (o_leds),
      .o_sw_rst           (o_sw_rst),
      .o_clock_control    (o_clock_control),
      .o_device_id        (device_id),
      .o_ref_freq         (o_ref_freq),
      .o_ref_freq_changed (o_ref_freq_changed),
      .o_sfp_rs_drive     (o_sfp_rs_drive)
   );

   // One monitor per SFP+ cage
   for (genvar g = 0; g < bus_pkg::NUM_SFP; g++) begin : g_sfp
      sfp_status_monitor monitor (
         .clk          (clk),
         .i_reset      (i_reset),
         .i_pins       (i_sfp_pins[g]),
         .i_phy_status (i_sfp_phy_status[g]),
         .i_clear      (sfp_clear[g]),
         .o_status     (sfp_status[g])
      );
   end

   readback_mux rb_mux0 (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_rb_sel       (rb_sel),
      .i_device_id    (device_id),
      .i_clock_status (i_clock_status),
      .i_sfp_status   (sfp_status),
      .o_rb_data      (o_rb_data)
   );

endmodule

// ==== hw/bus_pkg.sv ====
// Register map, field widths, reset values and readback word layout shared by the bus block
package bus_pkg;

   // ----------------------------------------
   // Bus widths
   // ----------------------------------------
   localparam int SR_AWIDTH = 8;
   localparam int RB_AWIDTH = 8;
   localparam int DATA_W    = 32;

   // Settings bus addresses
   localparam logic [SR_AWIDTH-1:0] SR_LEDS       = 8'd0;
   localparam logic [SR_AWIDTH-1:0] SR_SW_RST     = 8'd1;
   localparam logic [SR_AWIDTH-1:0] SR_CLOCK_CTRL = 8'd2;
   localparam logic [SR_AWIDTH-1:0] SR_DEVICE_ID  = 8'd3;
   localparam logic [SR_AWIDTH-1:0] SR_REF_FREQ   = 8'd4;
   localparam logic [SR_AWIDTH-1:0] SR_SFPP_CTRL0 = 8'd8;
   localparam logic [SR_AWIDTH-1:0] SR_SFPP_CTRL1 = 8'd9;

   // Readback bus addresses
   localparam logic [RB_AWIDTH-1:0] RB_COUNTER      = 8'd0;
   localparam logic [RB_AWIDTH-1:0] RB_CLK_STATUS   = 8'd3;
   localparam logic [RB_AWIDTH-1:0] RB_COMPAT_NUM   = 8'd6;
   localparam logic [RB_AWIDTH-1:0] RB_RFNOC_INFO   = 8'd7;
   localparam logic [RB_AWIDTH-1:0] RB_SFPP_STATUS0 = 8'd8;
   localparam logic [RB_AWIDTH-1:0] RB_SFPP_STATUS1 = 8'd9;

   // ----------------------------------------
   // Register and field widths
   // ----------------------------------------
   localparam int LEDS_W       = 2;
   localparam int SW_RST_W     = 4;
   localparam int CLK_CTRL_W   = 8;
   localparam int CLK_STATUS_W = 8;
   localparam int DEVICE_ID_W  = 16;
   localparam int SFPP_CTRL_W  = 2;
   localparam int PHY_STATUS_W = 16;
   localparam int SFP_RSVD_W   = 10;
   localparam int NUM_SFP      = 2;

   // One write enable slot per settings register
   localparam int WE_LEDS       = 0;
   localparam int WE_SW_RST     = 1;
   localparam int WE_CLK_CTRL   = 2;
   localparam int WE_DEVICE_ID  = 3;
   localparam int WE_REF_FREQ   = 4;
   localparam int WE_SFPP_CTRL0 = 5;
   localparam int NUM_WR_EN     = WE_SFPP_CTRL0 + NUM_SFP;

   // Reset values
   // Bit 6 of clock control turns the GPSDO on
   localparam logic [CLK_CTRL_W-1:0] CLK_CTRL_RESET = 8'h40;
   localparam logic [DATA_W-1:0]     REF_FREQ_RESET = 32'd10_000_000;

   // Identification words
   localparam logic [15:0] COMPAT_MAJOR   = 16'h0025;
   localparam logic [15:0] COMPAT_MINOR   = 16'h0000;
   localparam logic [15:0] RFNOC_PROTOVER = 16'h0100;

   // ----------------------------------------
   // Types
   // ----------------------------------------
   typedef enum logic [2:0] {
      RBS_ZERO,
      RBS_COUNTER,
      RBS_CLK,
      RBS_COMPAT,
      RBS_INFO,
      RBS_SFP0,
      RBS_SFP1
   } rb_sel_t;

   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfp_pins_t;

   // Status word layout on the readback bus from the MSB down
   typedef struct packed {
      logic [PHY_STATUS_W-1:0] phy_status;
      logic [SFP_RSVD_W-1:0]   reserved;
      sfp_pins_t               changed;
      sfp_pins_t               value;
   } sfp_status_t;

   typedef union packed {
      logic [DATA_W-1:0] raw;
      sfp_status_t       sfp;
   } rb_word_u;

endpackage

// ==== hw/control_regs.sv ====
// Settings registers written from the decoded settings bus, with reset defaults and change pulse
module control_regs (
   input  logic                            clk,
   input  logic                            i_reset,
   input  logic [bus_pkg::NUM_WR_EN-1:0]   i_wr_en,
   input  logic [bus_pkg::DATA_W-1:0]      i_set_data,
   output logic [bus_pkg::LEDS_W-1:0]      o_leds,
   output logic [bus_pkg::SW_RST_W-1:0]    o_sw_rst,
   output logic [bus_pkg::CLK_CTRL_W-1:0]  o_clock_control,
   output logic [bus_pkg::DEVICE_ID_W-1:0] o_device_id,
   output logic [bus_pkg::DATA_W-1:0]      o_ref_freq,
   output logic                            o_ref_freq_changed,
   output logic [bus_pkg::SFPP_CTRL_W-1:0] o_sfp_rs_drive [bus_pkg::NUM_SFP]
);

   // ----------------------------------------
   // Board control registers
   // ----------------------------------------
   // Soft reset bits
   //   0  PHY
   //   1  radio clock domain
   //   2  radio clock PLL
   //   3  ADC IDELAYCTRL
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_leds          <= '0;
         o_sw_rst        <= '0;
         o_clock_control <= bus_pkg::CLK_CTRL_RESET;
         o_device_id     <= '0;
         o_ref_freq      <= bus_pkg::REF_FREQ_RESET;
      end else begin
         if (i_wr_en[bus_pkg::WE_LEDS]) begin
            o_leds <= i_set_data[bus_pkg::LEDS_W-1:0];
         end
         if (i_wr_en[bus_pkg::WE_SW_RST]) begin
            o_sw_rst <= i_set_data[bus_pkg::SW_RST_W-1:0];
         end
         if (i_wr_en[bus_pkg::WE_CLK_CTRL]) begin
            o_clock_control <= i_set_data[bus_pkg::CLK_CTRL_W-1:0];
         end
         if (i_wr_en[bus_pkg::WE_DEVICE_ID]) begin
            o_device_id <= i_set_data[bus_pkg::DEVICE_ID_W-1:0];
         end
         if (i_wr_en[bus_pkg::WE_REF_FREQ]) begin
            o_ref_freq <= i_set_data;
         end
      end
   end

   // Pulse lines up with the new ref_freq value
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_ref_freq_changed <= 1'b0;
      end else begin
         o_ref_freq_changed <= i_wr_en[bus_pkg::WE_REF_FREQ];
      end
   end

   // ----------------------------------------
   // SFP+ RS pin control
   // ----------------------------------------
   // A set bit pulls the matching RS pin low outside this block
   for (genvar g = 0; g < bus_pkg::NUM_SFP; g++) begin : g_rs
      always_ff @(posedge clk) begin
         if (i_reset) begin
            o_sfp_rs_drive[g] <= '0;
         end else if (i_wr_en[bus_pkg::WE_SFPP_CTRL0+g]) begin
            o_sfp_rs_drive[g] <= i_set_data[bus_pkg::SFPP_CTRL_W-1:0];
         end
      end
   end

endmodule

// ==== hw/readback_mux.sv ====
// Readback word selection with the free-running cycle counter and a one-cycle registered output
module readback_mux (
   input  logic                             clk,
   input  logic                             i_reset,
   input  bus_pkg::rb_sel_t                 i_rb_sel,
   input  logic [bus_pkg::DEVICE_ID_W-1:0]  i_device_id,
   input  logic [bus_pkg::CLK_STATUS_W-1:0] i_clock_status,
   input  bus_pkg::sfp_status_t             i_sfp_status [bus_pkg::NUM_SFP],
   output logic [bus_pkg::DATA_W-1:0]       o_rb_data
);

   logic [bus_pkg::DATA_W-1:0] counter;
   bus_pkg::rb_word_u          rb_word;

   // ----------------------------------------
   // Cycle counter
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (i_reset) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;
      end
   end

   // ----------------------------------------
   // Word selection
   // ----------------------------------------
   always_comb begin
      rb_word.raw = '0;
      case (i_rb_sel)
         bus_pkg::RBS_COUNTER: begin
            rb_word.raw = counter;
         end
         bus_pkg::RBS_CLK: begin
            rb_word.raw = {{(bus_pkg::DATA_W-bus_pkg::CLK_STATUS_W){1'b0}}, i_clock_status};
         end
         bus_pkg::RBS_COMPAT: begin
            rb_word.raw = {bus_pkg::COMPAT_MAJOR, bus_pkg::COMPAT_MINOR};
         end
         bus_pkg::RBS_INFO: begin
            rb_word.raw = {i_device_id, bus_pkg::RFNOC_PROTOVER};
         end
         // Status words go through the struct view
         bus_pkg::RBS_SFP0: begin
            rb_word.sfp = i_sfp_status[0];
         end
         bus_pkg::RBS_SFP1: begin
            rb_word.sfp = i_sfp_status[1];
         end
         default: begin
            rb_word.raw = '0;
         end
      endcase
   end

   // Address sampled on one edge and data valid after it
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_rb_data <= '0;
      end else begin
         o_rb_data <= rb_word.raw;
      end
   end

endmodule

// ==== hw/setting_decoder.sv ====
// Address decoder turning settings and readback addresses into write enables, select and clears
module setting_decoder (
   // Clock and reset serve the bound bus checks only
   input  logic                          clk,
   input  logic                          i_reset,
   input  logic                          i_set_stb,
   input  logic [bus_pkg::SR_AWIDTH-1:0] i_set_addr,
   input  logic [bus_pkg::RB_AWIDTH-1:0] i_rb_addr,
   input  logic                          i_rb_rd_stb,
   output logic [bus_pkg::NUM_WR_EN-1:0] o_wr_en,
   output bus_pkg::rb_sel_t              o_rb_sel,
   output logic                          o_sfp_clear [bus_pkg::NUM_SFP]
);

   // ----------------------------------------
   // Settings writes
   // ----------------------------------------
   always_comb begin
      o_wr_en = '0;
      if (i_set_stb) begin
         case (i_set_addr)
            bus_pkg::SR_LEDS:       o_wr_en[bus_pkg::WE_LEDS]         = 1'b1;
            bus_pkg::SR_SW_RST:     o_wr_en[bus_pkg::WE_SW_RST]       = 1'b1;
            bus_pkg::SR_CLOCK_CTRL: o_wr_en[bus_pkg::WE_CLK_CTRL]     = 1'b1;
            bus_pkg::SR_DEVICE_ID:  o_wr_en[bus_pkg::WE_DEVICE_ID]    = 1'b1;
            bus_pkg::SR_REF_FREQ:   o_wr_en[bus_pkg::WE_REF_FREQ]     = 1'b1;
            bus_pkg::SR_SFPP_CTRL0: o_wr_en[bus_pkg::WE_SFPP_CTRL0]   = 1'b1;
            bus_pkg::SR_SFPP_CTRL1: o_wr_en[bus_pkg::WE_SFPP_CTRL0+1] = 1'b1;
            default:                o_wr_en                           = '0;
         endcase
      end
   end

   // ----------------------------------------
   // Readback select
   // ----------------------------------------
   always_comb begin
      case (i_rb_addr)
         bus_pkg::RB_COUNTER:      o_rb_sel = bus_pkg::RBS_COUNTER;
         bus_pkg::RB_CLK_STATUS:   o_rb_sel = bus_pkg::RBS_CLK;
         bus_pkg::RB_COMPAT_NUM:   o_rb_sel = bus_pkg::RBS_COMPAT;
         bus_pkg::RB_RFNOC_INFO:   o_rb_sel = bus_pkg::RBS_INFO;
         bus_pkg::RB_SFPP_STATUS0: o_rb_sel = bus_pkg::RBS_SFP0;
         bus_pkg::RB_SFPP_STATUS1: o_rb_sel = bus_pkg::RBS_SFP1;
         // Unmapped addresses read zero
         default:                  o_rb_sel = bus_pkg::RBS_ZERO;
      endcase
   end

   // Status words sit at consecutive addresses and clear on read
   always_comb begin
      for (int p = 0; p < bus_pkg::NUM_SFP; p++) begin
         o_sfp_clear[p] = i_rb_rd_stb &&
            (i_rb_addr == bus_pkg::RB_SFPP_STATUS0 + p[bus_pkg::RB_AWIDTH-1:0]);
      end
   end

endmodule

// ==== hw/sfp_status_monitor.sv ====
// Per-port SFP+ status capture that synchronizes module pins and PHY bits and latches pin changes
module sfp_status_monitor (
   input  logic                             clk,
   input  logic                             i_reset,
   input  bus_pkg::sfp_pins_t               i_pins,
   input  logic [bus_pkg::PHY_STATUS_W-1:0] i_phy_status,
   input  logic                             i_clear,
   output bus_pkg::sfp_status_t             o_status
);

   logic [$bits(bus_pkg::sfp_pins_t)+bus_pkg::PHY_STATUS_W-1:0] sync_meta;
   logic [$bits(bus_pkg::sfp_pins_t)+bus_pkg::PHY_STATUS_W-1:0] sync_q;
   bus_pkg::sfp_pins_t               pins_sync;
   bus_pkg::sfp_pins_t               pins_prev;
   bus_pkg::sfp_pins_t               pins_chgd;
   logic [bus_pkg::PHY_STATUS_W-1:0] phy_sync;

   // ----------------------------------------
   // Two-stage synchronizer
   // ----------------------------------------
   // All bits are asynchronous to clk and treated independently
   always_ff @(posedge clk) begin
      sync_meta <= {i_pins, i_phy_status};
      sync_q    <= sync_meta;
   end

   assign {pins_sync, phy_sync} = sync_q;

   // Previous value for edge detection
   always_ff @(posedge clk) begin
      pins_prev <= pins_sync;
   end

   // ----------------------------------------
   // Sticky change bits
   // ----------------------------------------
   // Clear wins over an edge seen in the same cycle
   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         pins_chgd <= '0;
      end else begin
         pins_chgd <= pins_chgd | (pins_sync ^ pins_prev);
      end
   end

   always_comb begin
      o_status.phy_status = phy_sync;
      o_status.reserved   = '0;
      o_status.changed    = pins_chgd;
      o_status.value      = pins_sync;
   end

endmodule

// ==== sources.f ====
hw/bus_pkg.sv
hw/setting_decoder.sv
hw/control_regs.sv
hw/sfp_status_monitor.sv
hw/readback_mux.sv
hw/bus_int_top.sv
tests/bus_int_sva.sv
tests/tb_bus_int.sv

// ==== tests/bus_int_sva.sv ====
// Bound concurrent checks on decoder enables, clear pulses and the ref-frequency pulse
module bus_int_sva (
   input logic                          clk,
   input logic                          i_reset,
   input logic [bus_pkg::NUM_WR_EN-1:0] i_wr_en,
   input logic                          i_rb_rd_stb,
   input logic [bus_pkg::NUM_SFP-1:0]   i_sfp_clear,
   input logic                          i_ref_freq_changed
);

   // At most one register written per strobe
   a_wr_en_onehot: assert property (@(posedge clk) disable iff (i_reset)
      $onehot0(i_wr_en))
      else $error("write enable not one-hot");

   // Pulse only after a ref-frequency write
   a_pulse_follows_write: assert property (@(posedge clk) disable iff (i_reset)
      i_ref_freq_changed |-> $past(i_wr_en[bus_pkg::WE_REF_FREQ]))
      else $error("ref freq pulse without write");

   a_pulse_one_cycle: assert property (@(posedge clk) disable iff (i_reset)
      (i_ref_freq_changed && !i_wr_en[bus_pkg::WE_REF_FREQ]) |=> !i_ref_freq_changed)
      else $error("ref freq pulse longer than one cycle");

   a_clear_needs_stb: assert property (@(posedge clk) disable iff (i_reset)
      (|i_sfp_clear) |-> i_rb_rd_stb)
      else $error("status clear without read strobe");

endmodule

bind setting_decoder bus_int_sva decoder_sva (
   .clk                (clk),
   .i_reset            (i_reset),
   .i_wr_en            (o_wr_en),
   .i_rb_rd_stb        (i_rb_rd_stb),
   .i_sfp_clear        ({o_sfp_clear[1], o_sfp_clear[0]}),
   .i_ref_freq_changed (1'b0)
);

bind control_regs bus_int_sva regs_sva (
   .clk                (clk),
   .i_reset            (i_reset),
   .i_wr_en            (i_wr_en),
   .i_rb_rd_stb        (1'b0),
   .i_sfp_clear        ('0),
   .i_ref_freq_changed (o_ref_freq_changed)
);

// ==== tests/tb_bus_int.sv ====
// Directed testbench for the bus block, run as top module tb_bus_int under Verilator
module tb_bus_int;

   logic                 clk;
   logic                 reset;
   logic                 set_stb;
   logic [7:0]           set_addr;
   logic [31:0]          set_data;
   logic [7:0]           rb_addr;
   logic                 rb_rd_stb;
   logic [31:0]          rb_data;
   logic [7:0]           clock_status;
   bus_pkg::sfp_pins_t   sfp_pins [bus_pkg::NUM_SFP];
   logic [15:0]          phy_status [bus_pkg::NUM_SFP];
   logic [1:0]           leds;
   logic [3:0]           sw_rst;
   logic [7:0]           clock_control;
   logic [31:0]          ref_freq;
   logic                 ref_freq_changed;
   logic [1:0]           rs_drive [bus_pkg::NUM_SFP];
   int                   errors;

   bus_int_top dut0 (
      .clk                (clk),
      .i_reset            (reset),
      .i_set_stb          (set_stb),
      .i_set_addr         (set_addr),
      .i_set_data         (set_data),
      .i_rb_addr          (rb_addr),
      .i_rb_rd_stb        (rb_rd_stb),
      .o_rb_data          (rb_data),
      .i_clock_status     (clock_status),
      .i_sfp_pins         (sfp_pins),
      .i_sfp_phy_status   (phy_status),
      .o_leds             (leds),
      .o_sw_rst           (sw_rst),
      .o_clock_control    (clock_control),
      .o_ref_freq         (ref_freq),
      .o_ref_freq_changed (ref_freq_changed),
      .o_sfp_rs_drive     (rs_drive)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   // ----------------------------------------
   // Bus tasks
   // ----------------------------------------
   task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      set_stb  <= 1'b1;
      set_addr <= addr;
      set_data <= data;
      @(posedge clk);
      set_stb <= 1'b0;
      @(negedge clk);
   endtask

   // Strobe high clears sticky bits of a status word
   task automatic rb_read(input logic [7:0] addr, input logic stb, output logic [31:0] data);
      @(posedge clk);
      rb_addr   <= addr;
      rb_rd_stb <= stb;
      @(posedge clk);
      rb_rd_stb <= 1'b0;
      @(negedge clk);
      data = rb_data;
   endtask

   task automatic poll_status(input logic [7:0] addr, input logic [31:0] mask,
                              input logic [31:0] want);
      logic [31:0] word;
      int          tries;
      tries = 0;
      word  = '0;
      while (((word & mask) != want) && tries < 10) begin
         rb_read(addr, 1'b0, word);
         tries++;
      end
      if ((word & mask) != want) begin
         $display("Timeout waiting for status at readback address %0d", addr);
         errors++;
      end
   endtask

   // ----------------------------------------
   // Tests
   // ----------------------------------------
   task automatic verify_reset_values();
      logic [31:0] word;
      if (leds != 0 || sw_rst != 0 || rs_drive[0] != 0 || rs_drive[1] != 0) begin
         $display("** Error %0t: control outputs not zero after reset", $time);
         errors++;
      end
      if (clock_control != 8'h40 || ref_freq != 32'd10_000_000 || ref_freq_changed) begin
         $display("** Error %0t: clock control or ref freq reset value wrong", $time);
         errors++;
      end
      rb_read(8'd6, 1'b0, word);
      if (word != 32'h0025_0000) begin
         $display("** Error %0t: compat read %h", $time, word);
         errors++;
      end
      rb_read(8'd7, 1'b0, word);
      if (word != 32'h0000_0100) begin
         $display("** Error %0t: info read %h after reset", $time, word);
         errors++;
      end
   endtask

   task automatic write_registers();
      logic [31:0] d;
      logic [31:0] word;
      logic [1:0]  exp_leds;
      logic [3:0]  exp_rst;
      logic [7:0]  exp_clk;
      logic [15:0] exp_id;
      logic [1:0]  exp_rs [bus_pkg::NUM_SFP];
      logic [31:0] exp_freq;
      d = $urandom;
      exp_leds = d[1:0];
      bus_write(8'd0, d);
      if (leds != exp_leds) begin
         $display("** Error %0t: leds %h expected %h", $time, leds, exp_leds);
         errors++;
      end
      d = $urandom;
      exp_rst = d[3:0];
      bus_write(8'd1, d);
      if (sw_rst != exp_rst) begin
         $display("** Error %0t: sw_rst %h expected %h", $time, sw_rst, exp_rst);
         errors++;
      end
      d = $urandom;
      exp_clk = d[7:0];
      bus_write(8'd2, d);
      if (clock_control != exp_clk) begin
         $display("** Error %0t: clock control %h expected %h", $time, clock_control, exp_clk);
         errors++;
      end
      d = $urandom;
      exp_id = d[15:0];
      bus_write(8'd3, d);
      rb_read(8'd7, 1'b0, word);
      if (word != {exp_id, 16'h0100}) begin
         $display("** Error %0t: info read %h with device id %h", $time, word, exp_id);
         errors++;
      end
      for (int p = 0; p < bus_pkg::NUM_SFP; p++) begin
         d = $urandom;
         exp_rs[p] = d[1:0];
         bus_write(8'd8 + 8'(p), d);
         if (rs_drive[p] != exp_rs[p]) begin
            $display("** Error %0t: rs drive %0d is %h expected %h", $time, p, rs_drive[p],
                     exp_rs[p]);
            errors++;
         end
      end
      d = $urandom;
      exp_freq = d;
      bus_write(8'd4, d);
      if (ref_freq != exp_freq || !ref_freq_changed) begin
         $display("** Error %0t: ref freq %h or change pulse wrong", $time, ref_freq);
         errors++;
      end
      @(negedge clk);
      if (ref_freq_changed) begin
         $display("** Error %0t: ref freq pulse longer than one cycle", $time);
         errors++;
      end
      // Unmapped address leaves every register alone
      bus_write(8'd5, $urandom);
      if (leds != exp_leds || sw_rst != exp_rst || clock_control != exp_clk ||
          ref_freq != exp_freq || rs_drive[0] != exp_rs[0] || rs_drive[1] != exp_rs[1] ||
          ref_freq_changed) begin
         $display("** Error %0t: write to unmapped address changed a register", $time);
         errors++;
      end
      rb_read(8'd7, 1'b0, word);
      if (word != {exp_id, 16'h0100}) begin
         $display("** Error %0t: device id changed by unmapped write, info %h", $time, word);
         errors++;
      end
   endtask

   task automatic read_counter_and_status();
      logic [31:0] first;
      logic [31:0] second;
      logic [7:0]  cs;
      int          k;
      k = $urandom_range(20, 2);
      rb_read(8'd0, 1'b0, first);
      repeat (k) @(negedge clk);
      second = rb_data;
      if (second - first != 32'(k)) begin
         $display("** Error %0t: counter step %0d expected %0d", $time, second - first, k);
         errors++;
      end
      cs = 8'($urandom);
      @(posedge clk);
      clock_status <= cs;
      rb_read(8'd3, 1'b0, first);
      if (first != {24'd0, cs}) begin
         $display("** Error %0t: clock status read %h expected %h", $time, first, cs);
         errors++;
      end
      rb_read(8'd42, 1'b0, first);
      if (first != 0) begin
         $display("** Error %0t: unknown address read %h", $time, first);
         errors++;
      end
   endtask

   task automatic toggle_sfp_pins();
      bus_pkg::rb_word_u mask;
      bus_pkg::rb_word_u word;
      logic [2:0]        level;
      level = 3'b000;
      for (int i = 0; i < 3; i++) begin
         level = level | (3'b001 << i);
         @(posedge clk);
         sfp_pins[0] <= bus_pkg::sfp_pins_t'(level);
         mask.raw = '0;
         mask.sfp.changed = bus_pkg::sfp_pins_t'(3'b001 << i);
         mask.sfp.value   = bus_pkg::sfp_pins_t'(3'b001 << i);
         poll_status(8'd8, mask.raw, mask.raw);
         rb_read(8'd8, 1'b1, word.raw);
         if (word.sfp.changed != (3'b001 << i)) begin
            $display("** Error %0t: pin %0d changed bits %b", $time, i, word.sfp.changed);
            errors++;
         end
         rb_read(8'd8, 1'b1, word.raw);
         if (word.sfp.changed != 0 || word.sfp.value != level) begin
            $display("** Error %0t: after clear changed %b value %b", $time,
                     word.sfp.changed, word.sfp.value);
            errors++;
         end
      end
      rb_read(8'd9, 1'b1, word.raw);
      if (word.sfp.changed != 0 || word.sfp.value != 0) begin
         $display("** Error %0t: port 1 disturbed, word %h", $time, word.raw);
         errors++;
      end
   endtask

   task automatic sweep_phy_status();
      logic [15:0] v;
      for (int p = 0; p < bus_pkg::NUM_SFP; p++) begin
         v = 16'($urandom);
         @(posedge clk);
         phy_status[p] <= v;
         poll_status(8'd8 + 8'(p), 32'hffff_0000, {v, 16'd0});
      end
   endtask

   // Watchdog against a hung run
   initial begin
      repeat (20000) @(posedge clk);
      $display("Run did not finish before the watchdog limit");
      $display("Simulation failed");
      $finish;
   end

   initial begin
      void'($urandom(30));
      errors       = 0;
      reset        = 1'b1;
      set_stb      = 1'b0;
      set_addr     = '0;
      set_data     = '0;
      rb_addr      = '0;
      rb_rd_stb    = 1'b0;
      clock_status = '0;
      for (int p = 0; p < bus_pkg::NUM_SFP; p++) begin
         sfp_pins[p]   = '0;
         phy_status[p] = '0;
      end
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      verify_reset_values();
      write_registers();
      read_counter_and_status();
      toggle_sfp_pins();
      sweep_phy_status();
      $display("Checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
